//--- verilog/sa_ctrl_defines.svh
`ifndef SA_CTRL_DEFINES_SVH
`define SA_CTRL_DEFINES_SVH

// Array geometry
`define SA_N_ROWS          4
`define SA_N_COLS          4
`define SA_MAX_FILTER      3

// Per-row ROM field widths, 4 rows x 7 bits per word
`define SA_SEL_W           2
`define SA_NCOL_W          2
`define SA_TR_W            2
`define SA_ROM_W           28

// Counter and address widths
`define SA_FEATURE_ADDR_W  16
`define SA_CHANNEL_W       6
`define SA_ROM_ADDR_W      10
`define SA_DRAIN_W         4

// Phase lengths in clock cycles
`define SA_READY_CYCLES    3
`define SA_DRAIN_BASE      6

`endif

//--- verilog/sa_ctrl_pkg.sv
`include "sa_ctrl_defines.svh"

package sa_ctrl_pkg;

    // One ROM control word, fields packed from bit 0 upward
    typedef logic [`SA_ROM_W-1:0] rom_word_t;

    // Per-row fields
    typedef logic [`SA_SEL_W-1:0]  f_sel_t;
    typedef logic [`SA_NCOL_W-1:0] col_num_t;
    typedef logic [`SA_TR_W-1:0]   tr_sel_t;

    // Layer settings and counters
    typedef logic [$clog2(`SA_MAX_FILTER+1)-1:0] filter_size_t;
    typedef logic [`SA_CHANNEL_W-1:0]            channel_t;
    typedef logic [`SA_FEATURE_ADDR_W-1:0]       feature_addr_t;
    typedef logic [`SA_ROM_ADDR_W-1:0]           rom_addr_t;
    typedef logic [`SA_DRAIN_W-1:0]              drain_t;

    typedef enum logic [2:0] {
        IDLE,
        WAIT_WEIGHT,
        LOAD,
        WAIT_BRAM,
        READY,
        START,
        DRAIN,
        NEXT_CHANNEL
    } phase_t;

endpackage

//--- verilog/sa_step_if.sv
`timescale 1ns/1ps
`include "sa_ctrl_defines.svh"

// Phase strobes from the sequencer to the row registers
interface sa_step_if
    import sa_ctrl_pkg::*;
();

    logic      idle;
    logic      load;
    rom_addr_t rom_addr;
    logic      channel_pass_start;

    modport sequencer (
        output idle,
        output load,
        output rom_addr,
        output channel_pass_start
    );

    modport rows (
        input idle,
        input load,
        input rom_addr,
        input channel_pass_start
    );

endinterface

//--- verilog/sa_layer_cfg.sv
`timescale 1ns/1ps
`include "sa_ctrl_defines.svh"

module sa_layer_cfg
    import sa_ctrl_pkg::*;
(
    input  logic                             clk_i,
    input  logic                             sel_mux_tr_rst,
    input  logic                             idle_i,
    input  filter_size_t                     filter_size_i,
    input  channel_t                         total_num_channels_i,
    input  feature_addr_t                    num_input_a_round_i,
    output drain_t                           drain_len_o,
    output channel_t                         channels_per_pass_o,
    output feature_addr_t                    inputs_per_round_o,
    output channel_t                         total_channels_o,
    output col_num_t [`SA_N_ROWS-1:0]        row_num_o,
    output logic     [`SA_N_ROWS-1:0]        sel_mux_node_o
);

    filter_size_t filter_size;
    filter_size_t fs_eff;

    // Settings follow the inputs while idle and freeze for the layer
    always_ff @(posedge clk_i or posedge sel_mux_tr_rst) begin
        if (sel_mux_tr_rst) begin
            filter_size        <= '0;
            total_channels_o   <= '0;
            inputs_per_round_o <= '0;
        end else if (idle_i) begin
            filter_size        <= filter_size_i;
            total_channels_o   <= total_num_channels_i;
            inputs_per_round_o <= num_input_a_round_i;
        end
    end

    // A zero filter size behaves as size 1
    assign fs_eff = (filter_size == '0) ? filter_size_t'(1) : filter_size;

    // 2 * (size - 1) + base
    assign drain_len_o = drain_t'({fs_eff - filter_size_t'(1), 1'b0}) +
                         drain_t'(`SA_DRAIN_BASE);

    assign channels_per_pass_o = channel_t'(`SA_N_ROWS) / channel_t'(fs_eff);

    ////////////////////////////////////////////////////////////////////
    // Row mapping, rows fold onto the filter height
    ////////////////////////////////////////////////////////////////////
    always_comb begin
        col_num_t row_phase;
        row_phase = '0;
        for (int i = 0; i < `SA_N_ROWS; i++) begin
            if (row_phase == col_num_t'(fs_eff))
                row_phase = '0;
            row_num_o[i] = row_phase + col_num_t'(1);
            // Last row of each filter does not pass its sum on
            sel_mux_node_o[i] = (row_num_o[i] != col_num_t'(fs_eff));
            row_phase = row_phase + col_num_t'(1);
        end
    end

endmodule

//--- verilog/sa_phase_fsm.sv
`timescale 1ns/1ps
`include "sa_ctrl_defines.svh"

module sa_phase_fsm
    import sa_ctrl_pkg::*;
(
    input  logic          clk_i,
    input  logic          sel_mux_tr_rst,
    input  logic          input_ready_i,
    input  logic          weight_ready_i,
    input  logic          bram_ready_i,
    input  drain_t        drain_len_i,
    input  channel_t      channels_per_pass_i,
    input  feature_addr_t inputs_per_round_i,
    input  channel_t      total_channels_i,
    sa_step_if.sequencer  step,
    output logic          rst_o,
    output logic          load_o,
    output logic          ready_o,
    output logic          start_op_o,
    output logic          rd_weight_ld_o,
    output logic          rd_feature_ld_o,
    output logic          rd_rom_signals_ld_o,
    output logic          layer_done_o,
    output feature_addr_t in_feature_addr_o
);

    phase_t        p_state;
    phase_t        n_state;
    feature_addr_t phase_cnt;
    feature_addr_t feature_addr;
    rom_addr_t     rom_addr;
    channel_t      channel_cnt;
    logic          idle_q;
    logic          load_q;
    logic          pass_start_q;
    logic          phase_last;

    // Final cycle of the counted phases
    always_comb begin
        case (p_state)
            LOAD:    phase_last = (phase_cnt == feature_addr_t'(`SA_N_COLS - 1));
            READY:   phase_last = (phase_cnt == feature_addr_t'(`SA_READY_CYCLES - 1));
            START:   phase_last = (phase_cnt == inputs_per_round_i - feature_addr_t'(1));
            DRAIN:   phase_last = (phase_cnt == feature_addr_t'(drain_len_i) - feature_addr_t'(1));
            default: phase_last = 1'b0;
        endcase
    end

    ////////////////////////////////////////////////////////////////////
    // Next phase
    ////////////////////////////////////////////////////////////////////
    always_comb begin
        n_state = p_state;
        case (p_state)
            IDLE, NEXT_CHANNEL: begin
                if (input_ready_i && weight_ready_i)
                    n_state = LOAD;
                else if (input_ready_i)
                    n_state = WAIT_WEIGHT;
            end
            WAIT_WEIGHT: begin
                if (weight_ready_i)
                    n_state = LOAD;
            end
            LOAD: begin
                if (phase_last)
                    n_state = WAIT_BRAM;
            end
            WAIT_BRAM: begin
                if (bram_ready_i)
                    n_state = READY;
            end
            READY: begin
                if (phase_last)
                    n_state = START;
            end
            // One round of inputs, no handshake sampled here
            START: begin
                if (phase_last)
                    n_state = DRAIN;
            end
            DRAIN: begin
                if (phase_last)
                    n_state = (channel_cnt >= total_channels_i) ? IDLE : NEXT_CHANNEL;
            end
            default: n_state = IDLE;
        endcase
    end

    ////////////////////////////////////////////////////////////////////
    // Phase register, counters and registered strobes
    ////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk_i or posedge sel_mux_tr_rst) begin
        if (sel_mux_tr_rst) begin
            p_state         <= IDLE;
            phase_cnt       <= '0;
            feature_addr    <= '0;
            rom_addr        <= '0;
            channel_cnt     <= '0;
            rst_o           <= 1'b1;
            idle_q          <= 1'b1;
            load_q          <= 1'b0;
            pass_start_q    <= 1'b0;
            ready_o         <= 1'b0;
            start_op_o      <= 1'b0;
            rd_feature_ld_o <= 1'b0;
            layer_done_o    <= 1'b0;
        end else begin
            p_state <= n_state;

            // Restarts on every phase change
            if (n_state != p_state)
                phase_cnt <= '0;
            else
                phase_cnt <= phase_cnt + feature_addr_t'(1);

            if (p_state == START && n_state == START)
                feature_addr <= feature_addr + feature_addr_t'(1);
            else
                feature_addr <= '0;

            // Keeps counting across passes and layers
            if (p_state == LOAD)
                rom_addr <= rom_addr + rom_addr_t'(1);

            if (n_state == IDLE)
                channel_cnt <= '0;
            else if (p_state == START && n_state == DRAIN)
                channel_cnt <= channel_cnt + channels_per_pass_i;

            // Array stays in reset while a fresh layer waits for weights
            rst_o           <= (n_state == IDLE) || (n_state == WAIT_WEIGHT && rst_o);
            idle_q          <= (n_state == IDLE);
            load_q          <= (n_state == LOAD);
            pass_start_q    <= (n_state == LOAD) && (p_state != LOAD) && (channel_cnt == '0);
            ready_o         <= (n_state == READY);
            start_op_o      <= (n_state == START) || (n_state == DRAIN);
            rd_feature_ld_o <= (n_state == READY) || (n_state == START);
            layer_done_o    <= (p_state == DRAIN) && (n_state == IDLE);
        end
    end

    assign load_o              = load_q;
    assign rd_weight_ld_o      = load_q;
    assign rd_rom_signals_ld_o = load_q;
    assign in_feature_addr_o   = feature_addr;

    assign step.idle               = idle_q;
    assign step.load               = load_q;
    assign step.rom_addr           = rom_addr;
    assign step.channel_pass_start = pass_start_q;

endmodule

//--- verilog/sa_row_signal_regs.sv
`timescale 1ns/1ps
`include "sa_ctrl_defines.svh"

module sa_row_signal_regs
    import sa_ctrl_pkg::*;
(
    input  logic                      clk_i,
    input  logic                      sel_mux_tr_rst,
    sa_step_if.rows                   step,
    input  rom_word_t                 rom_signals_data_i,
    output f_sel_t   [`SA_N_ROWS-1:0] f_sel_o,
    output col_num_t [`SA_N_ROWS-1:0] number_of_columns_o,
    output col_num_t [`SA_N_ROWS-1:0] column_num_o,
    output tr_sel_t  [`SA_N_ROWS-1:0] sel_mux_tr_o,
    output logic     [`SA_N_ROWS-1:0] en_adder_node_o
);

    // Field groups inside the ROM word
    localparam int NCOL_OFS = `SA_N_ROWS * `SA_SEL_W;
    localparam int TR_OFS   = NCOL_OFS + `SA_N_ROWS * `SA_NCOL_W;
    localparam int EN_OFS   = TR_OFS + `SA_N_ROWS * `SA_TR_W;

    f_sel_t   [`SA_N_ROWS-1:0] word_f_sel;
    col_num_t [`SA_N_ROWS-1:0] word_ncol;
    tr_sel_t  [`SA_N_ROWS-1:0] word_tr;
    logic     [`SA_N_ROWS-1:0] word_en;
    tr_sel_t  [`SA_N_ROWS-1:0] tr_stage;
    col_num_t [`SA_N_ROWS-1:0] col_cnt;
    col_num_t [`SA_N_ROWS-1:0] col_cnt_eff;
    logic                      col_restart;

    // Column counters restart with the first load of a layer
    assign col_restart = step.channel_pass_start;

    for (genvar r = 0; r < `SA_N_ROWS; r++) begin : g_split
        assign word_f_sel[r]  = rom_signals_data_i[r*`SA_SEL_W +: `SA_SEL_W];
        assign word_ncol[r]   = rom_signals_data_i[NCOL_OFS + r*`SA_NCOL_W +: `SA_NCOL_W];
        assign word_tr[r]     = rom_signals_data_i[TR_OFS + r*`SA_TR_W +: `SA_TR_W];
        assign word_en[r]     = rom_signals_data_i[EN_OFS + r];
        assign col_cnt_eff[r] = col_restart ? '0 : col_cnt[r];
    end

    ////////////////////////////////////////////////////////////////////
    // Row fields, transfer select lags two loads
    ////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk_i or posedge sel_mux_tr_rst) begin
        if (sel_mux_tr_rst) begin
            f_sel_o             <= '0;
            number_of_columns_o <= '0;
            en_adder_node_o     <= '0;
            tr_stage            <= '0;
            sel_mux_tr_o        <= '0;
        end else if (step.idle) begin
            f_sel_o             <= '0;
            number_of_columns_o <= '0;
            en_adder_node_o     <= '0;
            tr_stage            <= '0;
            sel_mux_tr_o        <= '0;
        end else if (step.load) begin
            f_sel_o             <= word_f_sel;
            number_of_columns_o <= word_ncol;
            en_adder_node_o     <= word_en;
            tr_stage            <= word_tr;
            sel_mux_tr_o        <= tr_stage;
        end
    end

    ////////////////////////////////////////////////////////////////////
    // Column numbers count down from the column count
    ////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk_i or posedge sel_mux_tr_rst) begin
        if (sel_mux_tr_rst) begin
            col_cnt      <= '0;
            column_num_o <= '0;
        end else if (step.idle) begin
            col_cnt      <= '0;
            column_num_o <= '0;
        end else if (step.load) begin
            for (int i = 0; i < `SA_N_ROWS; i++) begin
                column_num_o[i] <= word_ncol[i] - col_cnt_eff[i];
                // Wrap after the last column of this row
                if (col_cnt_eff[i] == word_ncol[i] - col_num_t'(1))
                    col_cnt[i] <= '0;
                else
                    col_cnt[i] <= col_cnt_eff[i] + col_num_t'(1);
            end
        end
    end

endmodule

//--- verilog/sa_controller_top.sv
`timescale 1ns/1ps
`include "sa_ctrl_defines.svh"

module sa_controller_top
    import sa_ctrl_pkg::*;
(
    input  logic                      clk_i,
    input  logic                      sel_mux_tr_rst,
    input  logic                      input_ready_i,
    input  logic                      weight_ready_i,
    input  logic                      bram_ready_i,
    input  filter_size_t              filter_size_i,
    input  channel_t                  total_num_channels_i,
    input  feature_addr_t             num_input_a_round_i,
    input  rom_word_t                 rom_signals_data_i,
    output rom_addr_t                 addrs_rom_signal_o,
    output feature_addr_t             in_feature_addr_o,
    output logic                      rst_o,
    output logic                      load_o,
    output logic                      ready_o,
    output logic                      start_op_o,
    output logic                      rd_weight_ld_o,
    output logic                      rd_feature_ld_o,
    output logic                      rd_rom_signals_ld_o,
    output logic                      layer_done_o,
    output f_sel_t   [`SA_N_ROWS-1:0] f_sel_o,
    output col_num_t [`SA_N_ROWS-1:0] number_of_columns_o,
    output col_num_t [`SA_N_ROWS-1:0] column_num_o,
    output tr_sel_t  [`SA_N_ROWS-1:0] sel_mux_tr_o,
    output logic     [`SA_N_ROWS-1:0] en_adder_node_o,
    output col_num_t [`SA_N_ROWS-1:0] row_num_o,
    output logic     [`SA_N_ROWS-1:0] sel_mux_node_o
);

    drain_t        drain_len;
    channel_t      channels_per_pass;
    feature_addr_t inputs_per_round;
    channel_t      total_channels;

    sa_step_if step ();

    // ROM is addressed straight from the sequencer
    assign addrs_rom_signal_o = step.rom_addr;

    sa_layer_cfg u_layer_cfg (
        .clk_i                (clk_i),
        .sel_mux_tr_rst       (sel_mux_tr_rst),
        .idle_i               (step.idle),
        .filter_size_i        (filter_size_i),
        .total_num_channels_i (total_num_channels_i),
        .num_input_a_round_i  (num_input_a_round_i),
        .drain_len_o          (drain_len),
        .channels_per_pass_o  (channels_per_pass),
        .inputs_per_round_o   (inputs_per_round),
        .total_channels_o     (total_channels),
        .row_num_o            (row_num_o),
        .sel_mux_node_o       (sel_mux_node_o)
    );

    sa_phase_fsm u_phase_fsm (
        .clk_i               (clk_i),
        .sel_mux_tr_rst      (sel_mux_tr_rst),
        .input_ready_i       (input_ready_i),
        .weight_ready_i      (weight_ready_i),
        .bram_ready_i        (bram_ready_i),
        .drain_len_i         (drain_len),
        .channels_per_pass_i (channels_per_pass),
        .inputs_per_round_i  (inputs_per_round),
        .total_channels_i    (total_channels),
        .step                (step.sequencer),
        .rst_o               (rst_o),
        .load_o              (load_o),
        .ready_o             (ready_o),
        .start_op_o          (start_op_o),
        .rd_weight_ld_o      (rd_weight_ld_o),
        .rd_feature_ld_o     (rd_feature_ld_o),
        .rd_rom_signals_ld_o (rd_rom_signals_ld_o),
        .layer_done_o        (layer_done_o),
        .in_feature_addr_o   (in_feature_addr_o)
    );

    sa_row_signal_regs u_row_regs (
        .clk_i               (clk_i),
        .sel_mux_tr_rst      (sel_mux_tr_rst),
        .step                (step.rows),
        .rom_signals_data_i  (rom_signals_data_i),
        .f_sel_o             (f_sel_o),
        .number_of_columns_o (number_of_columns_o),
        .column_num_o        (column_num_o),
        .sel_mux_tr_o        (sel_mux_tr_o),
        .en_adder_node_o     (en_adder_node_o)
    );

endmodule

//--- dv/sa_controller_tb.sv
`timescale 1ns/1ps
`include "sa_ctrl_defines.svh"

module sa_controller_tb
    import sa_ctrl_pkg::*;
();

    localparam int WAIT_LIMIT = 100;
    localparam int PASS_LIMIT = 400;
    localparam logic [31:0] ROM_SEED = 32'h38a8add6;

    logic          clk_i;
    logic          sel_mux_tr_rst;
    logic          input_ready_i;
    logic          weight_ready_i;
    logic          bram_ready_i;
    filter_size_t  filter_size_i;
    channel_t      total_num_channels_i;
    feature_addr_t num_input_a_round_i;
    rom_word_t     rom_signals_data_i;
    rom_addr_t     addrs_rom_signal_o;
    feature_addr_t in_feature_addr_o;
    logic          rst_o;
    logic          load_o;
    logic          ready_o;
    logic          start_op_o;
    logic          rd_weight_ld_o;
    logic          rd_feature_ld_o;
    logic          rd_rom_signals_ld_o;
    logic          layer_done_o;
    f_sel_t   [`SA_N_ROWS-1:0] f_sel_o;
    col_num_t [`SA_N_ROWS-1:0] number_of_columns_o;
    col_num_t [`SA_N_ROWS-1:0] column_num_o;
    tr_sel_t  [`SA_N_ROWS-1:0] sel_mux_tr_o;
    logic     [`SA_N_ROWS-1:0] en_adder_node_o;
    col_num_t [`SA_N_ROWS-1:0] row_num_o;
    logic     [`SA_N_ROWS-1:0] sel_mux_node_o;

    rom_word_t   rom [16];
    logic [31:0] seed;
    string       test_name;
    int          test_errs;
    int          total_errs;
    int          tests_run;
    int          tests_failed;
    rom_addr_t   exp_rom_addr;
    int          cur_fs;
    int          cur_inputs;

    // Row outputs captured right after the loads of a layer's first pass
    rom_addr_t                 snap_base;
    f_sel_t   [`SA_N_ROWS-1:0] snap_f_sel;
    col_num_t [`SA_N_ROWS-1:0] snap_ncol;
    col_num_t [`SA_N_ROWS-1:0] snap_col;
    tr_sel_t  [`SA_N_ROWS-1:0] snap_tr;
    logic     [`SA_N_ROWS-1:0] snap_en;
    col_num_t [`SA_N_ROWS-1:0] snap_row_num;
    logic     [`SA_N_ROWS-1:0] snap_node;

    sa_controller_top uut (
        .clk_i                (clk_i),
        .sel_mux_tr_rst       (sel_mux_tr_rst),
        .input_ready_i        (input_ready_i),
        .weight_ready_i       (weight_ready_i),
        .bram_ready_i         (bram_ready_i),
        .filter_size_i        (filter_size_i),
        .total_num_channels_i (total_num_channels_i),
        .num_input_a_round_i  (num_input_a_round_i),
        .rom_signals_data_i   (rom_signals_data_i),
        .addrs_rom_signal_o   (addrs_rom_signal_o),
        .in_feature_addr_o    (in_feature_addr_o),
        .rst_o                (rst_o),
        .load_o               (load_o),
        .ready_o              (ready_o),
        .start_op_o           (start_op_o),
        .rd_weight_ld_o       (rd_weight_ld_o),
        .rd_feature_ld_o      (rd_feature_ld_o),
        .rd_rom_signals_ld_o  (rd_rom_signals_ld_o),
        .layer_done_o         (layer_done_o),
        .f_sel_o              (f_sel_o),
        .number_of_columns_o  (number_of_columns_o),
        .column_num_o         (column_num_o),
        .sel_mux_tr_o         (sel_mux_tr_o),
        .en_adder_node_o      (en_adder_node_o),
        .row_num_o            (row_num_o),
        .sel_mux_node_o       (sel_mux_node_o)
    );

    always #10 clk_i = ~clk_i;

    // ROM answers in the same cycle
    assign rom_signals_data_i = rom[addrs_rom_signal_o[3:0]];

    ////////////////////////////////////////////////////////////////////
    // Helpers
    ////////////////////////////////////////////////////////////////////
    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] s;
        s = x;
        s = s ^ (s << 13);
        s = s ^ (s >> 17);
        s = s ^ (s << 5);
        return s;
    endfunction

    // Group 0 f_sel, 1 column count, 2 transfer select
    function automatic logic [1:0] word_field(input rom_word_t w, input int group, input int row);
        return w[group * `SA_N_ROWS * 2 + row * 2 +: 2];
    endfunction

    task automatic tick();
        @(posedge clk_i);
        #1;
    endtask

    task automatic check_value(input string what, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            $display("FAILED %s %s: expected %0h, actual %0h", test_name, what, expected, actual);
            test_errs++;
        end
    endtask

    task automatic report_problem(input string msg);
        $display("ERROR in %s: %s", test_name, msg);
        test_errs++;
    endtask

    task automatic start_test(input string name);
        test_name = name;
        test_errs = 0;
    endtask

    task automatic finish_test();
        $display("%-20s %s (%0d failed checks)", test_name,
                 (test_errs == 0) ? "passed" : "failed", test_errs);
        tests_run++;
        total_errs += test_errs;
        if (test_errs != 0)
            tests_failed++;
    endtask

    // Follows one pass from its first LOAD cycle to the end of DRAIN
    task automatic follow_pass(input int weight_hold, input int bram_hold,
                               input logic last_pass, input logic take_snap);
        int   cyc;
        int   n_load;
        int   n_ready;
        int   n_start;
        int   n_feat;
        int   feat_idx;
        int   bram_wait;
        logic seen_start;
        logic finished;
        input_ready_i  = 1'b1;
        weight_ready_i = (weight_hold == 0);
        bram_ready_i   = (bram_hold == 0);
        cyc = 0;
        while (load_o !== 1'b1 && cyc < WAIT_LIMIT) begin
            tick();
            cyc++;
            if (cyc <= weight_hold)
                check_value("load_o while weights pending", 0, load_o);
            if (cyc == weight_hold)
                weight_ready_i = 1'b1;
        end
        input_ready_i  = 1'b0;
        weight_ready_i = 1'b0;
        if (load_o !== 1'b1) begin
            report_problem("load_o never went high");
            bram_ready_i = 1'b0;
            return;
        end
        n_load = 0;
        n_ready = 0;
        n_start = 0;
        n_feat = 0;
        feat_idx = 0;
        bram_wait = 0;
        seen_start = 1'b0;
        finished = 1'b0;
        cyc = 0;
        while (!finished && cyc < PASS_LIMIT) begin
            // LOAD covers the first four cycles of the pass
            check_value("load_o", cyc < `SA_N_COLS, load_o);
            check_value("rd_weight_ld_o", cyc < `SA_N_COLS, rd_weight_ld_o);
            check_value("rd_rom_signals_ld_o", cyc < `SA_N_COLS, rd_rom_signals_ld_o);
            if (load_o)
                n_load++;
            // WAIT_BRAM lies between the last load and the first ready cycle
            if (n_load == `SA_N_COLS && !load_o && !ready_o && n_ready == 0) begin
                bram_wait++;
                if (bram_wait == 1) begin
                    check_value("ROM address after loads",
                                exp_rom_addr + rom_addr_t'(`SA_N_COLS), addrs_rom_signal_o);
                    if (take_snap) begin
                        snap_base    = exp_rom_addr;
                        snap_f_sel   = f_sel_o;
                        snap_ncol    = number_of_columns_o;
                        snap_col     = column_num_o;
                        snap_tr      = sel_mux_tr_o;
                        snap_en      = en_adder_node_o;
                        snap_row_num = row_num_o;
                        snap_node    = sel_mux_node_o;
                    end
                end
                if (!bram_ready_i && bram_wait >= bram_hold)
                    bram_ready_i = 1'b1;
            end
            if (ready_o) begin
                n_ready++;
                check_value("in_feature_addr_o in READY", 0, in_feature_addr_o);
                if (n_ready == 1)
                    check_value("WAIT_BRAM cycles", (bram_hold > 0) ? bram_hold : 1, bram_wait);
            end
            if (rd_feature_ld_o)
                n_feat++;
            if (start_op_o) begin
                seen_start = 1'b1;
                n_start++;
            end
            if (start_op_o && rd_feature_ld_o) begin
                check_value("in_feature_addr_o", feat_idx, in_feature_addr_o);
                feat_idx++;
            end
            if (seen_start && !start_op_o) begin
                finished = 1'b1;
            end else begin
                tick();
                cyc++;
            end
        end
        bram_ready_i = 1'b0;
        exp_rom_addr = exp_rom_addr + rom_addr_t'(`SA_N_COLS);
        if (!finished) begin
            report_problem("pass did not reach its end");
            return;
        end
        check_value("load cycles", `SA_N_COLS, n_load);
        check_value("ready cycles", `SA_READY_CYCLES, n_ready);
        check_value("start_op cycles", cur_inputs + 2 * (cur_fs - 1) + `SA_DRAIN_BASE, n_start);
        check_value("feature read cycles", `SA_READY_CYCLES + cur_inputs, n_feat);
        check_value("features streamed", cur_inputs, feat_idx);
        check_value("layer_done_o at pass end", last_pass, layer_done_o);
        check_value("rst_o at pass end", last_pass, rst_o);
        if (last_pass) begin
            tick();
            check_value("layer_done_o after pulse", 0, layer_done_o);
            check_value("rst_o back in IDLE", 1, rst_o);
        end
    endtask

    task automatic layer_sequence(input int fs, input int channels, input int inputs,
                                  input int weight_hold, input int bram_hold);
        int   chan;
        logic first;
        cur_fs               = fs;
        cur_inputs           = inputs;
        filter_size_i        = filter_size_t'(fs);
        total_num_channels_i = channel_t'(channels);
        num_input_a_round_i  = feature_addr_t'(inputs);
        tick();
        tick();
        chan = 0;
        first = 1'b1;
        do begin
            // Each pass covers 4 / filter size channels
            chan = chan + `SA_N_ROWS / fs;
            follow_pass(weight_hold, bram_hold, chan >= channels, first);
            first = 1'b0;
        end while (chan < channels);
    endtask

    ////////////////////////////////////////////////////////////////////
    // Directed tests
    ////////////////////////////////////////////////////////////////////
    task automatic idle_outputs_hold();
        start_test("idle_outputs");
        for (int i = 0; i < 10; i++) begin
            check_value("rst_o", 1, rst_o);
            check_value("load_o", 0, load_o);
            check_value("ready_o", 0, ready_o);
            check_value("start_op_o", 0, start_op_o);
            check_value("rd_weight_ld_o", 0, rd_weight_ld_o);
            check_value("rd_feature_ld_o", 0, rd_feature_ld_o);
            check_value("rd_rom_signals_ld_o", 0, rd_rom_signals_ld_o);
            check_value("layer_done_o", 0, layer_done_o);
            check_value("addrs_rom_signal_o", 0, addrs_rom_signal_o);
            check_value("in_feature_addr_o", 0, in_feature_addr_o);
            check_value("f_sel_o", 0, f_sel_o);
            check_value("number_of_columns_o", 0, number_of_columns_o);
            check_value("column_num_o", 0, column_num_o);
            check_value("sel_mux_tr_o", 0, sel_mux_tr_o);
            check_value("en_adder_node_o", 0, en_adder_node_o);
            tick();
        end
        finish_test();
    endtask

    task automatic single_pass_sequence();
        start_test("single_pass");
        layer_sequence(3, 1, 5, 0, 0);
        finish_test();
    endtask

    task automatic row_fields_match_rom();
        col_num_t [`SA_N_ROWS-1:0] cnt;
        col_num_t [`SA_N_ROWS-1:0] exp_col;
        f_sel_t   [`SA_N_ROWS-1:0] exp_f_sel;
        col_num_t [`SA_N_ROWS-1:0] exp_ncol;
        tr_sel_t  [`SA_N_ROWS-1:0] exp_tr;
        logic     [`SA_N_ROWS-1:0] exp_en;
        col_num_t                  ncol;
        rom_word_t                 w;
        start_test("row_fields");
        cnt = '0;
        exp_tr = '0;
        for (int k = 0; k < `SA_N_COLS; k++) begin
            w = rom[4'(snap_base + rom_addr_t'(k))];
            for (int r = 0; r < `SA_N_ROWS; r++) begin
                ncol = word_field(w, 1, r);
                exp_col[r] = ncol - cnt[r];
                if (cnt[r] == col_num_t'(ncol - col_num_t'(1)))
                    cnt[r] = '0;
                else
                    cnt[r] = cnt[r] + col_num_t'(1);
                if (k == `SA_N_COLS - 2)
                    exp_tr[r] = word_field(w, 2, r);
                if (k == `SA_N_COLS - 1) begin
                    exp_f_sel[r] = word_field(w, 0, r);
                    exp_ncol[r]  = ncol;
                    exp_en[r]    = w[3 * `SA_N_ROWS * 2 + r];
                end
            end
        end
        check_value("f_sel_o", exp_f_sel, snap_f_sel);
        check_value("number_of_columns_o", exp_ncol, snap_ncol);
        check_value("en_adder_node_o", exp_en, snap_en);
        check_value("sel_mux_tr_o", exp_tr, snap_tr);
        check_value("column_num_o", exp_col, snap_col);
        finish_test();
    endtask

    task automatic two_pass_layer();
        col_num_t [`SA_N_ROWS-1:0] exp_row;
        logic     [`SA_N_ROWS-1:0] exp_node;
        start_test("two_passes");
        check_value("ROM address before layer", exp_rom_addr, addrs_rom_signal_o);
        layer_sequence(2, 4, 3, 0, 0);
        // Rows fold onto the filter height
        for (int r = 0; r < `SA_N_ROWS; r++) begin
            exp_row[r]  = col_num_t'(r % 2 + 1);
            exp_node[r] = (r % 2 + 1) != 2;
        end
        check_value("row_num_o", exp_row, snap_row_num);
        check_value("sel_mux_node_o", exp_node, snap_node);
        finish_test();
    endtask

    task automatic weight_and_bram_backpressure();
        start_test("backpressure");
        layer_sequence(1, 4, 4, 8, 8);
        finish_test();
    endtask

    initial begin
        clk_i                = 1'b0;
        sel_mux_tr_rst       = 1'b1;
        input_ready_i        = 1'b0;
        weight_ready_i       = 1'b0;
        bram_ready_i         = 1'b0;
        filter_size_i        = filter_size_t'(1);
        total_num_channels_i = '0;
        num_input_a_round_i  = '0;
        test_errs    = 0;
        total_errs   = 0;
        tests_run    = 0;
        tests_failed = 0;
        exp_rom_addr = '0;
        seed = ROM_SEED;
        for (int i = 0; i < 16; i++) begin
            seed = xorshift32(seed);
            rom[i] = seed[`SA_ROM_W-1:0];
        end
        repeat (2) @(posedge clk_i);
        #1;
        sel_mux_tr_rst = 1'b0;

        idle_outputs_hold();
        single_pass_sequence();
        row_fields_match_rom();
        two_pass_layer();
        weight_and_bram_backpressure();

        $display("%0d tests run, %0d failed, %0d failed checks",
                 tests_run, tests_failed, total_errs);
        if (total_errs == 0)
            $display("TEST PASS");
        else
            $display("TEST FAIL");
        $finish;
    end

endmodule

//--- project.f
+incdir+verilog
verilog/sa_ctrl_pkg.sv
verilog/sa_step_if.sv
verilog/sa_layer_cfg.sv
verilog/sa_phase_fsm.sv
verilog/sa_row_signal_regs.sv
verilog/sa_controller_top.sv
dv/sa_controller_tb.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal -f project.f --top-module sa_controller_tb -Mdir obj_dir
./obj_dir/Vsa_controller_tb > sim.log
cat sim.log

if grep -q "^TEST PASS$" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi
